//--- frontend.f
design/frontend_pkg.sv
design/fetch_unit.sv
design/fetch_queue.sv
design/fetch_decode_reg.sv
design/decoder.sv
design/frontend_top.sv
tb/frontend_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module frontend_tb \
		-f frontend.f -o frontend_sim
	./obj_dir/frontend_sim > sim.log 2>&1 || echo "RESULT: FAIL" >> sim.log
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/frontend_golden.txt
# M <pair address> <pair as slot 1 word then slot 0 word>
# R <redirect target>, applied once every E line above it has been taken
# E <pc> <op> <rd> <rj> <sign-extended immediate>
M 1c000000 1448d00228001401
M 1c000008 300040442fffe023
M 1c000010 5a0000e0fc0004a6
M 1c000040 5bfff00030000be1
M 1c000048 28000463a8000002
M 1c000100 02af347f29fffd2a
M 1c000108 2c0400c817fffc05
E 1c000000 0 01 00 00000005
E 1c000004 1 02 00 00001234
E 1c000008 2 03 01 fffffff8
E 1c00000c 3 04 02 00000010
E 1c000010 7 06 05 00000001
E 1c000014 4 00 07 ffff8000
R 1c000100
E 1c000100 0 0a 09 00007fff
E 1c000104 7 1f 03 ffffabcd
E 1c000108 1 05 00 ffffffff
E 1c00010c 2 08 06 00000100
R 1c000040
E 1c000040 3 01 1f 00000002
E 1c000044 4 00 00 fffffffc
E 1c000048 7 02 00 00000000
E 1c00004c 0 03 03 00000001

//--- tb/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

    localparam logic [31:0] PC_RESET = 32'h1c00_0000;

    logic              clk;
    logic              rstn = 1'b0;
    logic              redirect_valid = 1'b0;
    logic [31:0]       redirect_pc = '0;
    logic [63:0]       imem_rdata = '0;
    logic              dec_ready = 1'b0;
    logic              imem_req;
    logic [31:0]       imem_addr;
    logic              dec_valid;
    logic [31:0]       dec_pc;
    frontend_pkg::op_e dec_op;
    logic [4:0]        dec_rd;
    logic [4:0]        dec_rj;
    logic [31:0]       dec_imm;

    logic [63:0] mem [logic [31:0]];   // Instruction memory image, one pair per address.
    logic [31:0] exp_pc [$];
    logic [2:0]  exp_op [$];
    logic [4:0]  exp_rd [$];
    logic [4:0]  exp_rj [$];
    logic [31:0] exp_imm [$];
    int          redir_at [$];         // Number of outputs taken before each redirect.
    logic [31:0] redir_pc [$];

    int          errs [6];
    int          total;
    int          cycles = 0;
    int          cycle_limit = 100;
    int          redirects_done = 0;
    int          invalid_seen = 0;
    int          neg_imm_seen = 0;
    logic [31:0] seed = 32'hbb13_4490;

    frontend_top #(.PC_RESET(PC_RESET), .QUEUE_DEPTH(4)) UUT (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .imem_rdata     (imem_rdata),
        .dec_ready      (dec_ready),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_op         (dec_op),
        .dec_rd         (dec_rd),
        .dec_rj         (dec_rj),
        .dec_imm        (dec_imm)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with the decoded stream incomplete", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [63:0] mem_read(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {~addr, addr ^ 32'h9e37_79b9};   // Fill for words outside the image.
    endfunction

    task automatic report_mismatch(input int test_id, input string sig,
                                   input logic [31:0] exp_v, input logic [31:0] act_v);
        $display("FAILED at %0t ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
        errs[test_id]++;
    endtask

    task automatic print_test(input int test_id, input string name);
        $display("Test %0d %s: %s with %0d errors", test_id, name,
                 errs[test_id] == 0 ? "passed" : "failed", errs[test_id]);
    endtask

    function automatic bit load_golden();
        int          fd;
        string       line;
        logic [31:0] a;
        logic [63:0] p;
        logic [31:0] f1, f2, f3, f4;
        fd = $fopen("tb/frontend_golden.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") continue;
            if ($sscanf(line, "M %h %h", a, p) == 2) begin
                mem[a] = p;
            end else if ($sscanf(line, "R %h", a) == 1) begin
                redir_at.push_back(exp_pc.size());
                redir_pc.push_back(a);
            end else if ($sscanf(line, "E %h %h %h %h %h", a, f1, f2, f3, f4) == 5) begin
                exp_pc.push_back(a);
                exp_op.push_back(f1[2:0]);
                exp_rd.push_back(f2[4:0]);
                exp_rj.push_back(f3[4:0]);
                exp_imm.push_back(f4);
            end
        end
        $fclose(fd);
        return exp_pc.size() > 0;
    endfunction

    task automatic apply_reset();
        rstn           = 1'b0;
        redirect_valid = 1'b0;
        dec_ready      = 1'b0;
        imem_rdata     = '0;
        repeat (2) begin
            @(posedge clk);
            if (dec_valid !== 1'b0) report_mismatch(1, "dec_valid", 32'd0, 32'(dec_valid));
            if (imem_req !== 1'b0) report_mismatch(1, "imem_req", 32'd0, 32'(imem_req));
        end
        @(negedge clk);
        rstn = 1'b1;
    endtask

    // ========================================
    // Output checks
    // ========================================
    task automatic check_output(input int test_id, input int idx);
        int op_test;
        int imm_test;
        op_test  = (exp_op[idx] == 3'd7) ? 5 : test_id;   // Unknown opcodes count for test 5.
        imm_test = exp_imm[idx][31] ? 5 : test_id;
        if (op_test == 5) invalid_seen++;
        if (imm_test == 5) neg_imm_seen++;
        if (dec_pc !== exp_pc[idx]) begin
            report_mismatch(test_id, "dec_pc", exp_pc[idx], dec_pc);
        end
        if (dec_op !== exp_op[idx]) begin
            report_mismatch(op_test, "dec_op", 32'(exp_op[idx]), 32'(dec_op));
        end
        if (dec_rd !== exp_rd[idx]) begin
            report_mismatch(test_id, "dec_rd", 32'(exp_rd[idx]), 32'(dec_rd));
        end
        if (dec_rj !== exp_rj[idx]) begin
            report_mismatch(test_id, "dec_rj", 32'(exp_rj[idx]), 32'(dec_rj));
        end
        if (dec_imm !== exp_imm[idx]) begin
            report_mismatch(imm_test, "dec_imm", exp_imm[idx], dec_imm);
        end
    endtask

    task automatic run_stream(input int test_id, input bit rand_ready);
        int          idx = 0;
        int          ri = 0;
        int          cyc = 0;
        bit          pend = 1'b0;
        bit          first_req = 1'b1;
        bit          want_target = 1'b0;
        bit          stalled = 1'b0;
        logic [31:0] pend_addr = '0;
        logic [31:0] target = '0;
        logic [31:0] rnd;
        logic [31:0] held_pc = '0;
        logic [2:0]  held_op = '0;
        logic [4:0]  held_rd = '0;
        logic [4:0]  held_rj = '0;
        logic [31:0] held_imm = '0;
        apply_reset();
        while (idx < exp_pc.size()) begin
            imem_rdata = pend ? mem_read(pend_addr) : 64'd0;   // Answer the last request.
            if (ri < redir_at.size() && redir_at[ri] == idx) begin
                redirect_valid = 1'b1;
                redirect_pc    = redir_pc[ri];
                dec_ready      = 1'b0;
            end else begin
                redirect_valid = 1'b0;
                rnd            = lcg_next();
                dec_ready      = rand_ready ? rnd[20] : 1'b1;
            end
            @(posedge clk);
            cyc++;
            pend      = imem_req;
            pend_addr = imem_addr;
            if (imem_req && first_req) begin
                first_req = 1'b0;
                if (imem_addr !== PC_RESET) report_mismatch(1, "imem_addr", PC_RESET, imem_addr);
                if (cyc != 2) report_mismatch(1, "first imem_req cycle", 32'd2, 32'(cyc));
            end
            if (stalled) begin
                if (dec_valid !== 1'b1) begin
                    report_mismatch(test_id, "dec_valid", 32'd1, 32'(dec_valid));
                end
                if (dec_pc !== held_pc) begin
                    report_mismatch(test_id, "dec_pc", held_pc, dec_pc);
                end
                if (dec_op !== held_op) begin
                    report_mismatch(test_id, "dec_op", 32'(held_op), 32'(dec_op));
                end
                if (dec_rd !== held_rd) begin
                    report_mismatch(test_id, "dec_rd", 32'(held_rd), 32'(dec_rd));
                end
                if (dec_rj !== held_rj) begin
                    report_mismatch(test_id, "dec_rj", 32'(held_rj), 32'(dec_rj));
                end
                if (dec_imm !== held_imm) begin
                    report_mismatch(test_id, "dec_imm", held_imm, dec_imm);
                end
            end
            stalled  = dec_valid && !dec_ready && !redirect_valid;
            held_pc  = dec_pc;
            held_op  = dec_op;
            held_rd  = dec_rd;
            held_rj  = dec_rj;
            held_imm = dec_imm;
            if (redirect_valid) begin
                ri++;
                redirects_done++;
                want_target = 1'b1;
                target      = redirect_pc;
            end else if (dec_valid && dec_ready) begin
                if (want_target && dec_pc !== target) begin
                    report_mismatch(4, "dec_pc", target, dec_pc);
                end
                want_target = 1'b0;
                check_output(test_id, idx);
                idx++;
            end
            @(negedge clk);
        end
        redirect_valid = 1'b0;
        dec_ready      = 1'b0;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        if (load_golden()) begin
            cycle_limit = 20 * 2 * exp_pc.size() + 100;   // Both passes over the stream.
            run_stream(2, 1'b0);
            print_test(1, "reset and first fetch");
            print_test(2, "stream with dec_ready high");
            run_stream(3, 1'b1);
            print_test(3, "stream with random dec_ready");
            if (redirects_done == 0) begin
                $display("Test 4 found no redirect in the golden data");
                errs[4]++;
            end
            print_test(4, "redirect");
            if (invalid_seen == 0 || neg_imm_seen == 0) begin
                $display("Test 5 found no unknown opcode or no negative immediate to check");
                errs[5]++;
            end
            print_test(5, "unknown opcode and sign extension");
        end else begin
            $display("The golden file could not be read or holds no expected outputs");
            errs[0]++;
        end
        total = errs.sum();
        $display("Summary: 5 tests, %0d errors, %0d cycles", total, cycles);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- design/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter logic [31:0] PC_RESET    = 32'h1c00_0000,
    parameter int          QUEUE_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            redirect_valid,
    input  logic [frontend_pkg::PC_W-1:0]   redirect_pc,
    input  logic [frontend_pkg::PAIR_W-1:0] imem_rdata,
    input  logic                            dec_ready,
    output logic                            imem_req,
    output logic [frontend_pkg::PC_W-1:0]   imem_addr,
    output logic                            dec_valid,
    output logic [frontend_pkg::PC_W-1:0]   dec_pc,
    output frontend_pkg::op_e               dec_op,
    output logic [frontend_pkg::REG_W-1:0]  dec_rd,
    output logic [frontend_pkg::REG_W-1:0]  dec_rj,
    output logic [frontend_pkg::INST_W-1:0] dec_imm
);

    // ========================================
    // Stage links
    // ========================================
    logic                            fq_valid;
    logic                            fq_ready;
    logic [frontend_pkg::PC_W-1:0]   fq_pc;
    logic [frontend_pkg::PAIR_W-1:0] fq_pair;

    logic                            fd_valid;
    logic                            fd_ready;
    logic [frontend_pkg::PC_W-1:0]   fd_pc;
    logic [frontend_pkg::PAIR_W-1:0] fd_pair;

    logic                            id_valid;
    logic                            id_ready;
    logic [frontend_pkg::PC_W-1:0]   id_pc;
    logic [frontend_pkg::PAIR_W-1:0] id_pair;

    fetch_unit #(.PC_RESET(PC_RESET)) u_fetch_unit (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .imem_rdata     (imem_rdata),
        .fq_ready       (fq_ready),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .fq_valid       (fq_valid),
        .fq_pc          (fq_pc),
        .fq_pair        (fq_pair)
    );

    // A redirect clears every later stage in the same cycle.
    fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_fetch_queue (
        .clk      (clk),
        .rstn     (rstn),
        .flush    (redirect_valid),
        .fq_valid (fq_valid),
        .fq_pc    (fq_pc),
        .fq_pair  (fq_pair),
        .fd_ready (fd_ready),
        .fq_ready (fq_ready),
        .fd_valid (fd_valid),
        .fd_pc    (fd_pc),
        .fd_pair  (fd_pair)
    );

    fetch_decode_reg #(.PC_RESET(PC_RESET)) u_fetch_decode_reg (
        .clk      (clk),
        .rstn     (rstn),
        .flush    (redirect_valid),
        .fd_valid (fd_valid),
        .fd_pc    (fd_pc),
        .fd_pair  (fd_pair),
        .id_ready (id_ready),
        .fd_ready (fd_ready),
        .id_valid (id_valid),
        .id_pc    (id_pc),
        .id_pair  (id_pair)
    );

    decoder u_decoder (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (redirect_valid),
        .id_valid  (id_valid),
        .id_pc     (id_pc),
        .id_pair   (id_pair),
        .dec_ready (dec_ready),
        .id_ready  (id_ready),
        .dec_valid (dec_valid),
        .dec_pc    (dec_pc),
        .dec_op    (dec_op),
        .dec_rd    (dec_rd),
        .dec_rj    (dec_rj),
        .dec_imm   (dec_imm)
    );

endmodule

//--- design/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            flush,
    input  logic                            id_valid,
    input  logic [frontend_pkg::PC_W-1:0]   id_pc,
    input  logic [frontend_pkg::PAIR_W-1:0] id_pair,
    input  logic                            dec_ready,
    output logic                            id_ready,
    output logic                            dec_valid,
    output logic [frontend_pkg::PC_W-1:0]   dec_pc,
    output frontend_pkg::op_e               dec_op,
    output logic [frontend_pkg::REG_W-1:0]  dec_rd,
    output logic [frontend_pkg::REG_W-1:0]  dec_rj,
    output logic [frontend_pkg::INST_W-1:0] dec_imm
);

    typedef enum logic {
        SLOT0,
        SLOT1
    } slot_e;

    slot_e                           state_q;
    logic                            hold_q;    // A pair is held for issue.
    logic [frontend_pkg::PC_W-1:0]   pc_q;
    logic [frontend_pkg::PAIR_W-1:0] pair_q;
    logic [frontend_pkg::INST_W-1:0] inst;
    logic [frontend_pkg::IMM_W-1:0]  imm_raw;

    // ========================================
    // Pair sequencing
    // ========================================
    // Next pair is taken while slot 1 leaves, so back to back pairs have no gap.
    assign id_ready = !hold_q || (state_q == SLOT1 && dec_ready);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= SLOT0;
            hold_q  <= 1'b0;
        end else if (flush) begin
            state_q <= SLOT0;
            hold_q  <= 1'b0;
        end else if (id_ready) begin
            state_q <= SLOT0;
            hold_q  <= id_valid;                 // A bubble leaves the decoder idle.
        end else if (dec_ready) begin
            state_q <= SLOT1;                    // Slot 0 taken, slot 1 goes next.
        end
    end

    always_ff @(posedge clk) begin
        if (id_ready && id_valid) begin
            pc_q   <= id_pc;
            pair_q <= id_pair;
        end
    end

    // ========================================
    // Field decode
    // ========================================
    always_comb begin
        inst = (state_q == SLOT1) ? pair_q[frontend_pkg::PAIR_W-1 -: frontend_pkg::INST_W]
                                  : pair_q[frontend_pkg::INST_W-1:0];
        case (inst[frontend_pkg::MAJOR_LSB +: frontend_pkg::MAJOR_W])
            frontend_pkg::MAJOR_ADDI:   dec_op = frontend_pkg::OP_ADDI;
            frontend_pkg::MAJOR_LUI:    dec_op = frontend_pkg::OP_LUI;
            frontend_pkg::MAJOR_LOAD:   dec_op = frontend_pkg::OP_LOAD;
            frontend_pkg::MAJOR_STORE:  dec_op = frontend_pkg::OP_STORE;
            frontend_pkg::MAJOR_BRANCH: dec_op = frontend_pkg::OP_BRANCH;
            default:                    dec_op = frontend_pkg::OP_INVALID;
        endcase
        imm_raw = inst[frontend_pkg::IMM_LSB +: frontend_pkg::IMM_W];
    end

    assign dec_valid = hold_q;
    assign dec_pc    = (state_q == SLOT1) ? pc_q + 32'd4 : pc_q;
    assign dec_rd    = inst[frontend_pkg::RD_LSB +: frontend_pkg::REG_W];
    assign dec_rj    = inst[frontend_pkg::RJ_LSB +: frontend_pkg::REG_W];
    assign dec_imm   = {{(frontend_pkg::INST_W-frontend_pkg::IMM_W){imm_raw[15]}}, imm_raw};

    // A stalled instruction stays on the outputs until it is taken.
    assert property (@(posedge clk) disable iff (!rstn)
        dec_valid && !dec_ready && !flush |=>
            dec_valid && $stable(dec_pc) && $stable(dec_op) && $stable(dec_imm));

endmodule

//--- design/fetch_decode_reg.sv
`timescale 1ns/1ps

module fetch_decode_reg #(
    parameter logic [31:0] PC_RESET = 32'h1c00_0000
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            flush,
    input  logic                            fd_valid,
    input  logic [frontend_pkg::PC_W-1:0]   fd_pc,
    input  logic [frontend_pkg::PAIR_W-1:0] fd_pair,
    input  logic                            id_ready,
    output logic                            fd_ready,
    output logic                            id_valid,
    output logic [frontend_pkg::PC_W-1:0]   id_pc,
    output logic [frontend_pkg::PAIR_W-1:0] id_pair
);

    localparam logic [frontend_pkg::PAIR_W-1:0] BUBBLE_PAIR =
        {frontend_pkg::INST_NOP, frontend_pkg::INST_NOP};

    logic load;     // Register takes a new value this cycle.
    logic bubble;   // The new value is a NOP bubble.

    // ========================================
    // Handshake
    // ========================================
    // The register moves whenever the decoder takes it or it holds nothing.
    assign load     = id_ready || !id_valid;
    assign fd_ready = load;
    assign bubble   = flush || (load && !fd_valid);

    // ========================================
    // Stage register
    // ========================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_valid <= 1'b0;
            id_pc    <= PC_RESET;
            id_pair  <= BUBBLE_PAIR;
        end else if (bubble) begin
            id_valid <= 1'b0;                    // Empty queue or flush leaves a NOP pair.
            id_pc    <= PC_RESET;
            id_pair  <= BUBBLE_PAIR;
        end else if (load) begin
            id_valid <= 1'b1;
            id_pc    <= fd_pc;
            id_pair  <= fd_pair;
        end
    end

    // A pair that the decoder has not taken is held as it is.
    assert property (@(posedge clk) disable iff (!rstn)
        id_valid && !id_ready && !flush |=> id_valid && $stable(id_pc) && $stable(id_pair));

endmodule

//--- design/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            flush,
    input  logic                            fq_valid,
    input  logic [frontend_pkg::PC_W-1:0]   fq_pc,
    input  logic [frontend_pkg::PAIR_W-1:0] fq_pair,
    input  logic                            fd_ready,
    output logic                            fq_ready,
    output logic                            fd_valid,
    output logic [frontend_pkg::PC_W-1:0]   fd_pc,
    output logic [frontend_pkg::PAIR_W-1:0] fd_pair
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [frontend_pkg::PC_W-1:0]   pc_mem   [QUEUE_DEPTH];
    logic [frontend_pkg::PAIR_W-1:0] pair_mem [QUEUE_DEPTH];

    // Pointers carry one extra bit to tell full from empty.
    logic [PTR_W:0] wr_ptr_q;
    logic [PTR_W:0] rd_ptr_q;
    logic [PTR_W:0] count;
    logic           full;
    logic           empty;
    logic           wr_en;
    logic           rd_en;

    // ========================================
    // Status
    // ========================================
    assign count = wr_ptr_q - rd_ptr_q;
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                   (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

    assign fq_ready = !full;
    assign fd_valid = !empty;

    assign wr_en = fq_valid && fq_ready && !flush;   // Flush discards the incoming pair too.
    assign rd_en = fd_valid && fd_ready && !flush;

    // ========================================
    // Pointers and storage
    // ========================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pc_mem[wr_ptr_q[PTR_W-1:0]]   <= fq_pc;
            pair_mem[wr_ptr_q[PTR_W-1:0]] <= fq_pair;
        end
    end

    // Head is read straight from storage.
    assign fd_pc   = pc_mem[rd_ptr_q[PTR_W-1:0]];
    assign fd_pair = pair_mem[rd_ptr_q[PTR_W-1:0]];

    // Occupancy stays within depth, so no write hit a full queue and no read an empty one.
    assert property (@(posedge clk) disable iff (!rstn)
        count <= (PTR_W+1)'(QUEUE_DEPTH));

    // A head that the stage register refuses stays at the head.
    assert property (@(posedge clk) disable iff (!rstn)
        fd_valid && !fd_ready && !flush |=> fd_valid && $stable(fd_pc) && $stable(fd_pair));

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [31:0] PC_RESET = 32'h1c00_0000
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            redirect_valid,
    input  logic [frontend_pkg::PC_W-1:0]   redirect_pc,
    input  logic [frontend_pkg::PAIR_W-1:0] imem_rdata,
    input  logic                            fq_ready,
    output logic                            imem_req,
    output logic [frontend_pkg::PC_W-1:0]   imem_addr,
    output logic                            fq_valid,
    output logic [frontend_pkg::PC_W-1:0]   fq_pc,
    output logic [frontend_pkg::PAIR_W-1:0] fq_pair
);

    logic                            run_q;       // Set on the first clock after reset.
    logic [frontend_pkg::PC_W-1:0]   pc_q;        // Address of the next request.
    logic [frontend_pkg::PC_W-1:0]   req_pc_q;    // Address of the pair in flight or in skid.
    logic                            pend_q;      // A response arrives this cycle.
    logic                            skid_q;      // Skid register holds a pair.
    logic [frontend_pkg::PAIR_W-1:0] skid_pair_q;

    // ========================================
    // Request side
    // ========================================
    // A new request goes out only when the current pair, if any, leaves this cycle.
    assign imem_req  = run_q && !redirect_valid && (!fq_valid || fq_ready);
    assign imem_addr = pc_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_q  <= 1'b0;
            pc_q   <= PC_RESET;
            pend_q <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            pend_q <= imem_req;                   // Memory answers one cycle later.
            if (redirect_valid) begin
                pc_q <= {redirect_pc[frontend_pkg::PC_W-1:3], 3'b000};
            end else if (imem_req) begin
                pc_q <= pc_q + 32'd8;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req) begin
            req_pc_q <= imem_addr;
        end
    end

    // ========================================
    // Response side and skid
    // ========================================
    assign fq_valid = pend_q || skid_q;           // The two never overlap.
    assign fq_pc    = req_pc_q;
    assign fq_pair  = skid_q ? skid_pair_q : imem_rdata;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            skid_q <= 1'b0;
        end else if (redirect_valid) begin
            skid_q <= 1'b0;                       // Drop whatever the old stream left.
        end else if (pend_q && !fq_ready) begin
            skid_q <= 1'b1;
        end else if (skid_q && fq_ready) begin
            skid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pend_q && !fq_ready) begin
            skid_pair_q <= imem_rdata;
        end
    end

    // Every request address is pair aligned.
    assert property (@(posedge clk) disable iff (!rstn)
        imem_req |-> imem_addr[2:0] == 3'b000);

    // A refused response is offered again, unchanged, on the next cycle.
    assert property (@(posedge clk) disable iff (!rstn)
        pend_q && !fq_ready && !redirect_valid |=> fq_valid && fq_pair == $past(imem_rdata));

endmodule

//--- design/frontend_pkg.sv
package frontend_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int INST_W = 32;               // One instruction word.
    localparam int PAIR_W = 2 * INST_W;       // Two words fetched per request.
    localparam int PC_W   = 32;
    localparam int REG_W  = 5;                // Register index.
    localparam int IMM_W  = 16;               // Raw immediate field before extension.

    // ========================================
    // Instruction fields
    // ========================================
    localparam int MAJOR_W   = 6;
    localparam int MAJOR_LSB = 26;            // Major opcode sits in bits 31..26.
    localparam int IMM_LSB   = 10;            // Immediate in bits 25..10.
    localparam int RJ_LSB    = 5;             // Source register in bits 9..5.
    localparam int RD_LSB    = 0;             // Destination register in bits 4..0.

    // Major opcode encodings.
    localparam logic [MAJOR_W-1:0] MAJOR_ADDI   = 6'h0a;
    localparam logic [MAJOR_W-1:0] MAJOR_LUI    = 6'h05;
    localparam logic [MAJOR_W-1:0] MAJOR_LOAD   = 6'h0b;
    localparam logic [MAJOR_W-1:0] MAJOR_STORE  = 6'h0c;
    localparam logic [MAJOR_W-1:0] MAJOR_BRANCH = 6'h16;

    // addi r0, r0, 0 serves as the NOP that fills a bubble.
    localparam logic [INST_W-1:0] INST_NOP = {MAJOR_ADDI, {(INST_W-MAJOR_W){1'b0}}};

    // ========================================
    // Decoded operations
    // ========================================
    typedef enum logic [2:0] {
        OP_ADDI    = 3'd0,
        OP_LUI     = 3'd1,
        OP_LOAD    = 3'd2,
        OP_STORE   = 3'd3,
        OP_BRANCH  = 3'd4,
        OP_INVALID = 3'd7                     // Any major opcode not listed above.
    } op_e;

endpackage
